//--- common/ncore_settings.svh
`ifndef NCORE_SETTINGS_SVH
`define NCORE_SETTINGS_SVH

// Datapath width of registers, ALU and data memory
`define NCORE_DW 16

// Instruction memory address width, 2 K bytes
`define NCORE_IAW 11

// Data memory address width, 2 K words
`define NCORE_DAW 11

// General register file depth
`define NCORE_NREG 16

// Zero, carry, borrow, shl-out, shr-out
`define NCORE_NFLAG 5

`endif

//--- common/ncore_pkg.sv
package ncore_pkg;

	//////////////////////////////
	// Instruction encoding
	//////////////////////////////

	// Upper nibble of the instruction byte
	typedef enum logic [3:0] {
		op_mva = 4'd0,
		op_mvb = 4'd1,
		op_shl = 4'd2,
		op_shr = 4'd3,
		op_and = 4'd4,
		op_orr = 4'd5,
		op_xor = 4'd6,
		op_add = 4'd7,
		op_sub = 4'd8,
		op_fmv = 4'd9,
		op_mvd = 4'd10,
		op_cob = 4'd11,
		op_mvp = 4'd12,
		op_jmp = 4'd13,
		op_coa = 4'd14,
		op_dmv = 4'd15
	} opcode_e;

	// Low nibble read as a register index
	typedef struct packed {
		opcode_e    op;
		logic [3:0] rs;
	} instr_reg_t;

	// Low nibble read as a small constant
	typedef struct packed {
		opcode_e    op;
		logic [3:0] imm;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

	//////////////////////////////
	// ALU and flags
	//////////////////////////////

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_shl,
		alu_shr,
		alu_and,
		alu_orr,
		alu_xor
	} alu_sel_e;

	// Bit positions in the flag register
	localparam int unsigned flag_zero   = 0;
	localparam int unsigned flag_carry  = 1;
	localparam int unsigned flag_borrow = 2;
	localparam int unsigned flag_shl    = 3;
	localparam int unsigned flag_shr    = 4;

endpackage

//--- ncore/ncore_sequencer.sv
`timescale 1ns/1ps

`include "ncore_settings.svh"

module ncore_sequencer import ncore_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rst_n,
	output logic                   o_imem_req,
	output logic [`NCORE_IAW-1:0]  o_imem_addr,
	input  logic                   i_imem_ack,
	input  logic [7:0]             i_imem_data,
	output logic                   o_dmem_req,
	output logic                   o_dmem_we,
	output logic [`NCORE_DAW-1:0]  o_dmem_addr,
	output logic [`NCORE_DW-1:0]   o_dmem_wdata,
	input  logic                   i_dmem_ack,
	input  logic [`NCORE_DW-1:0]   i_dmem_rdata,
	output instr_u                 o_instr,
	output logic                   o_exec,
	output logic [`NCORE_DW-1:0]   o_load_data,
	output logic                   o_load_we,
	input  logic                   i_jump,
	input  logic [`NCORE_IAW-1:0]  i_target,
	input  logic                   i_store,
	input  logic                   i_load,
	input  logic [`NCORE_DAW-1:0]  i_dp,
	input  logic [`NCORE_DW-1:0]   i_store_data
);

	// Instruction phases
	localparam logic [2:0] st_fetch_req = 3'd0;
	localparam logic [2:0] st_fetch_rel = 3'd1;
	localparam logic [2:0] st_exec      = 3'd2;
	localparam logic [2:0] st_data_req  = 3'd3;
	localparam logic [2:0] st_data_rel  = 3'd4;

	logic [2:0]            state;
	logic [`NCORE_IAW-1:0] ip;

	//////////////////////////////
	// Phase FSM and IP
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state      <= st_fetch_req;
			o_imem_req <= 1'b0;
			o_dmem_req <= 1'b0;
			o_dmem_we  <= 1'b0;
			ip         <= '0;
		end else begin
			case (state)
				st_fetch_req: begin
					// Ack is already low here, so raising req is safe
					if (o_imem_req && i_imem_ack) begin
						o_imem_req <= 1'b0;
						state      <= st_fetch_rel;
					end else begin
						o_imem_req <= 1'b1;
					end
				end
				st_fetch_rel: begin
					if (!i_imem_ack)
						state <= st_exec;
				end
				st_exec: begin
					ip <= i_jump ? i_target : ip + 1'b1;
					if (i_store || i_load) begin
						o_dmem_we <= i_store;
						state     <= st_data_req;
					end else begin
						state <= st_fetch_req;
					end
				end
				st_data_req: begin
					if (o_dmem_req && i_dmem_ack) begin
						o_dmem_req <= 1'b0;
						state      <= st_data_rel;
					end else begin
						o_dmem_req <= 1'b1;
					end
				end
				st_data_rel: begin
					if (!i_dmem_ack)
						state <= st_fetch_req;
				end
				default: state <= st_fetch_req;
			endcase
		end
	end

	// Instruction byte and data transfer payload
	always_ff @(posedge clk) begin
		if (state == st_fetch_req && o_imem_req && i_imem_ack)
			o_instr <= i_imem_data;
		if (state == st_exec) begin
			o_dmem_addr  <= i_dp;
			o_dmem_wdata <= i_store_data;
		end
	end

	assign o_imem_addr = ip;
	assign o_exec      = (state == st_exec);

	// Read data goes straight to the register file on the first ack cycle
	assign o_load_data = i_dmem_rdata;
	assign o_load_we   = (state == st_data_req) && o_dmem_req && i_dmem_ack && !o_dmem_we;

endmodule

//--- ncore/ncore_decode.sv
`timescale 1ns/1ps

`include "ncore_settings.svh"

module ncore_decode import ncore_pkg::*; (
	input  instr_u                   i_instr,
	input  logic                     i_exec,
	output logic                     o_load_a,
	output logic                     o_load_b,
	output logic                     o_use_const,
	output alu_sel_e                 o_alu_sel,
	output logic                     o_reg_we,
	output logic [`NCORE_NFLAG-1:0]  o_flag_mask,
	output logic                     o_dp_we,
	output logic                     o_jump_req,
	output logic                     o_store,
	output logic                     o_load
);

	logic                    load_a;
	logic                    load_b;
	logic                    reg_we;
	logic [`NCORE_NFLAG-1:0] mask;
	logic                    dp_we;
	logic                    jump_req;
	logic                    store;
	logic                    load;

	always_comb begin
		load_a      = 1'b0;
		load_b      = 1'b0;
		o_use_const = 1'b0;
		o_alu_sel   = alu_add;
		reg_we      = 1'b0;
		mask        = '0;
		dp_we       = 1'b0;
		jump_req    = 1'b0;
		store       = 1'b0;
		load        = 1'b0;
		case (i_instr.r.op)
			op_mva: load_a = 1'b1;
			op_mvb: load_b = 1'b1;
			op_coa: begin
				load_a      = 1'b1;
				o_use_const = 1'b1;
			end
			op_cob: begin
				load_b      = 1'b1;
				o_use_const = 1'b1;
			end
			op_shl: begin
				o_alu_sel                       = alu_shl;
				reg_we                          = 1'b1;
				mask[flag_zero]                 = 1'b1;
				mask[flag_shl]                  = 1'b1;
			end
			op_shr: begin
				o_alu_sel       = alu_shr;
				reg_we          = 1'b1;
				mask[flag_zero] = 1'b1;
				mask[flag_shr]  = 1'b1;
			end
			op_and: begin
				o_alu_sel       = alu_and;
				reg_we          = 1'b1;
				mask[flag_zero] = 1'b1;
			end
			op_orr: begin
				o_alu_sel       = alu_orr;
				reg_we          = 1'b1;
				mask[flag_zero] = 1'b1;
			end
			op_xor: begin
				o_alu_sel       = alu_xor;
				reg_we          = 1'b1;
				mask[flag_zero] = 1'b1;
			end
			// Add leaves zero alone and only touches carry
			op_add: begin
				o_alu_sel        = alu_add;
				reg_we           = 1'b1;
				mask[flag_carry] = 1'b1;
			end
			op_sub: begin
				o_alu_sel         = alu_sub;
				reg_we            = 1'b1;
				mask[flag_zero]   = 1'b1;
				mask[flag_borrow] = 1'b1;
			end
			op_fmv: reg_we   = 1'b1;
			op_mvd: store    = 1'b1;
			op_mvp: dp_we    = 1'b1;
			op_jmp: jump_req = 1'b1;
			op_dmv: load     = 1'b1;
			default: ;
		endcase
	end

	// Strobes only fire in the execute cycle
	assign o_load_a    = i_exec & load_a;
	assign o_load_b    = i_exec & load_b;
	assign o_reg_we    = i_exec & reg_we;
	assign o_flag_mask = {`NCORE_NFLAG{i_exec}} & mask;
	assign o_dp_we     = i_exec & dp_we;
	assign o_jump_req  = i_exec & jump_req;
	assign o_store     = i_exec & store;
	assign o_load      = i_exec & load;

endmodule

//--- ncore/ncore_execute.sv
`timescale 1ns/1ps

`include "ncore_settings.svh"

module ncore_execute import ncore_pkg::*; (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic                     i_load_a,
	input  logic                     i_load_b,
	input  logic                     i_use_const,
	input  logic [3:0]               i_const,
	input  logic [`NCORE_DW-1:0]     i_reg_val,
	input  alu_sel_e                 i_alu_sel,
	output logic [`NCORE_DW-1:0]     o_a,
	output logic [`NCORE_DW-1:0]     o_b,
	output logic [`NCORE_DW-1:0]     o_alu,
	output logic [`NCORE_NFLAG-1:0]  o_flag_cand
);

	logic [`NCORE_DW-1:0] operand;
	logic [3:0]           amt;
	logic [`NCORE_DW:0]   sum;
	logic [`NCORE_DW:0]   diff;
	logic [`NCORE_DW:0]   shl_ext;
	logic                 shr_out;

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	assign operand = i_use_const ? {{(`NCORE_DW-4){1'b0}}, i_const} : i_reg_val;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_a <= '0;
			o_b <= '0;
		end else begin
			if (i_load_a)
				o_a <= operand;
			if (i_load_b)
				o_b <= operand;
		end
	end

	//////////////////////////////
	// ALU
	//////////////////////////////

	// Shift amount is the low nibble of B
	assign amt = o_b[3:0];

	assign sum     = {1'b0, o_a} + {1'b0, o_b};
	assign diff    = {1'b0, o_a} - {1'b0, o_b};
	assign shl_ext = {1'b0, o_a} << amt;
	assign shr_out = (amt == 4'd0) ? 1'b0 : o_a[amt - 4'd1];

	always_comb begin
		case (i_alu_sel)
			alu_add: o_alu = sum[`NCORE_DW-1:0];
			alu_sub: o_alu = diff[`NCORE_DW-1:0];
			alu_shl: o_alu = shl_ext[`NCORE_DW-1:0];
			alu_shr: o_alu = o_a >> amt;
			alu_and: o_alu = o_a & o_b;
			alu_orr: o_alu = o_a | o_b;
			alu_xor: o_alu = o_a ^ o_b;
			default: o_alu = sum[`NCORE_DW-1:0];
		endcase
	end

	// Candidates for all flags, decode picks which ones land
	assign o_flag_cand[flag_zero]   = (o_alu == '0);
	assign o_flag_cand[flag_carry]  = sum[`NCORE_DW];
	assign o_flag_cand[flag_borrow] = diff[`NCORE_DW];
	assign o_flag_cand[flag_shl]    = shl_ext[`NCORE_DW];
	assign o_flag_cand[flag_shr]    = shr_out;

endmodule

//--- ncore/ncore_result.sv
`timescale 1ns/1ps

`include "ncore_settings.svh"

module ncore_result import ncore_pkg::*; (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  instr_u                   i_instr,
	input  logic                     i_reg_we,
	input  logic [`NCORE_NFLAG-1:0]  i_flag_mask,
	input  logic                     i_dp_we,
	input  logic                     i_jump_req,
	input  logic [`NCORE_DW-1:0]     i_alu,
	input  logic [`NCORE_NFLAG-1:0]  i_flag_cand,
	input  logic                     i_a0,
	input  logic [`NCORE_DW-1:0]     i_load_data,
	input  logic                     i_load_we,
	output logic [`NCORE_DW-1:0]     o_reg_val,
	output logic [`NCORE_NFLAG-1:0]  o_flags,
	output logic [`NCORE_DAW-1:0]    o_dp,
	output logic                     o_jump
);

	logic [`NCORE_DW-1:0] regs [`NCORE_NREG];
	logic [`NCORE_DW-1:0] wdata;

	//////////////////////////////
	// Register file
	//////////////////////////////

	// Write source by opcode
	always_comb begin
		case (i_instr.r.op)
			op_fmv: wdata = {{(`NCORE_DW-`NCORE_NFLAG){1'b0}}, o_flags};
			op_dmv: wdata = i_load_data;
			default: wdata = i_alu;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int k = 0; k < `NCORE_NREG; k++)
				regs[k] <= '0;
		end else if (i_reg_we || i_load_we) begin
			regs[i_instr.r.rs] <= wdata;
		end
	end

	// Same read port serves mvA/mvB, jmp target, mvD data and mvP
	assign o_reg_val = regs[i_instr.r.rs];

	//////////////////////////////
	// Flags and data pointer
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_flags <= '0;
		end else begin
			o_flags <= (o_flags & ~i_flag_mask) | (i_flag_cand & i_flag_mask);
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			o_dp <= '0;
		else if (i_dp_we)
			o_dp <= o_reg_val[`NCORE_DAW-1:0];
	end

	// Jump taken only when A is odd
	assign o_jump = i_jump_req & i_a0;

endmodule

//--- rtl/ncore_top.sv
`timescale 1ns/1ps

`include "ncore_settings.svh"

module ncore_top import ncore_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rst_n,
	output logic                   o_imem_req,
	output logic [`NCORE_IAW-1:0]  o_imem_addr,
	input  logic                   i_imem_ack,
	input  logic [7:0]             i_imem_data,
	output logic                   o_dmem_req,
	output logic                   o_dmem_we,
	output logic [`NCORE_DAW-1:0]  o_dmem_addr,
	output logic [`NCORE_DW-1:0]   o_dmem_wdata,
	input  logic                   i_dmem_ack,
	input  logic [`NCORE_DW-1:0]   i_dmem_rdata
);

	instr_u                  instr;
	logic                    exec;
	logic [`NCORE_DW-1:0]    load_data;
	logic                    load_we;
	logic                    jump;
	logic                    store;
	logic                    load;
	logic [`NCORE_DAW-1:0]   dp;
	logic [`NCORE_DW-1:0]    reg_val;
	logic                    load_a;
	logic                    load_b;
	logic                    use_const;
	alu_sel_e                alu_sel;
	logic                    reg_we;
	logic [`NCORE_NFLAG-1:0] flag_mask;
	logic                    dp_we;
	logic                    jump_req;
	logic [`NCORE_DW-1:0]    a;
	logic [`NCORE_DW-1:0]    alu;
	logic [`NCORE_NFLAG-1:0] flag_cand;

	ncore_sequencer u_sequencer (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.o_imem_req   (o_imem_req),
		.o_imem_addr  (o_imem_addr),
		.i_imem_ack   (i_imem_ack),
		.i_imem_data  (i_imem_data),
		.o_dmem_req   (o_dmem_req),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.i_dmem_ack   (i_dmem_ack),
		.i_dmem_rdata (i_dmem_rdata),
		.o_instr      (instr),
		.o_exec       (exec),
		.o_load_data  (load_data),
		.o_load_we    (load_we),
		.i_jump       (jump),
		.i_target     (reg_val[`NCORE_IAW-1:0]),
		.i_store      (store),
		.i_load       (load),
		.i_dp         (dp),
		.i_store_data (reg_val)
	);

	ncore_decode u_decode (
		.i_instr     (instr),
		.i_exec      (exec),
		.o_load_a    (load_a),
		.o_load_b    (load_b),
		.o_use_const (use_const),
		.o_alu_sel   (alu_sel),
		.o_reg_we    (reg_we),
		.o_flag_mask (flag_mask),
		.o_dp_we     (dp_we),
		.o_jump_req  (jump_req),
		.o_store     (store),
		.o_load      (load)
	);

	// Constant comes from the immediate view of the same byte
	ncore_execute u_execute (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_load_a    (load_a),
		.i_load_b    (load_b),
		.i_use_const (use_const),
		.i_const     (instr.i.imm),
		.i_reg_val   (reg_val),
		.i_alu_sel   (alu_sel),
		.o_a         (a),
		.o_b         (),
		.o_alu       (alu),
		.o_flag_cand (flag_cand)
	);

	ncore_result u_result (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_instr     (instr),
		.i_reg_we    (reg_we),
		.i_flag_mask (flag_mask),
		.i_dp_we     (dp_we),
		.i_jump_req  (jump_req),
		.i_alu       (alu),
		.i_flag_cand (flag_cand),
		.i_a0        (a[0]),
		.i_load_data (load_data),
		.i_load_we   (load_we),
		.o_reg_val   (reg_val),
		.o_flags     (),
		.o_dp        (dp),
		.o_jump      (jump)
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

// Free-running 100 ns clock
module tb_clock (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

endmodule

//--- dv/ncore_chk.sv
`timescale 1ns/1ps

module ncore_chk (
	input logic clk,
	input logic i_rst_n,
	input logic i_imem_req,
	input logic i_imem_ack,
	input logic i_dmem_req,
	input logic i_dmem_ack
);

	//////////////////////////////
	// Four-phase rules
	//////////////////////////////

	a_imem_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_imem_req && !i_imem_ack |=> i_imem_req)
		else $error("fetch req dropped before its ack");

	a_dmem_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_dmem_req && !i_dmem_ack |=> i_dmem_req)
		else $error("data req dropped before its ack");

	// A new req only once the previous ack has fallen
	a_imem_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(i_imem_req) |-> !i_imem_ack)
		else $error("fetch req raised while ack high");

	a_dmem_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(i_dmem_req) |-> !i_dmem_ack)
		else $error("data req raised while ack high");

	a_one_port: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_imem_req && i_dmem_req))
		else $error("fetch and data req high together");

	a_reset_idle: assert property (@(posedge clk)
		!i_rst_n |=> !i_imem_req && !i_dmem_req)
		else $error("req high during reset");

endmodule

bind ncore_sequencer ncore_chk u_chk (
	.clk        (clk),
	.i_rst_n    (i_rst_n),
	.i_imem_req (o_imem_req),
	.i_imem_ack (i_imem_ack),
	.i_dmem_req (o_dmem_req),
	.i_dmem_ack (i_dmem_ack)
);

//--- dv/tb_ncore.sv
`timescale 1ns/1ps

`include "ncore_settings.svh"

module tb_ncore import ncore_pkg::*; ();

	logic                  clk;
	logic                  rst_n;
	logic                  imem_req;
	logic [`NCORE_IAW-1:0] imem_addr;
	logic                  imem_ack;
	logic [7:0]            imem_data;
	logic                  dmem_req;
	logic                  dmem_we;
	logic [`NCORE_DAW-1:0] dmem_addr;
	logic [`NCORE_DW-1:0]  dmem_wdata;
	logic                  dmem_ack;
	logic [`NCORE_DW-1:0]  dmem_rdata;

	logic [7:0]            imem [2**`NCORE_IAW];
	logic [`NCORE_DW-1:0]  dmem [2**`NCORE_DAW];
	logic [`NCORE_IAW-1:0] exp_fetch [$];
	logic [`NCORE_DAW-1:0] exp_waddr [$];
	logic [`NCORE_DW-1:0]  exp_wdata [$];
	logic [`NCORE_IAW-1:0] want_ip;
	logic [`NCORE_DAW-1:0] want_addr;
	logic [`NCORE_DW-1:0]  want_data;
	logic                  imem_req_q;
	logic                  dmem_req_q;
	logic                  rst_q = 1'b1;
	integer                seed = 32'h25e1_8e97;
	string                 cur_test;
	bit                    slow;
	int                    pc;
	int                    errors;
	int                    fetches;
	int                    writes;
	int                    budget;
	int                    cycles;
	opcode_e               alu_ops [7] = '{op_shl, op_shr, op_and, op_orr, op_xor, op_add, op_sub};

	tb_clock u_clock (.o_clk(clk));

	ncore_top dut (
		.clk          (clk),
		.i_rst_n      (rst_n),
		.o_imem_req   (imem_req),
		.o_imem_addr  (imem_addr),
		.i_imem_ack   (imem_ack),
		.i_imem_data  (imem_data),
		.o_dmem_req   (dmem_req),
		.o_dmem_we    (dmem_we),
		.o_dmem_addr  (dmem_addr),
		.o_dmem_wdata (dmem_wdata),
		.i_dmem_ack   (dmem_ack),
		.i_dmem_rdata (dmem_rdata)
	);

	function automatic logic [`NCORE_DW-1:0] fill_word(input logic [`NCORE_DAW-1:0] addr);
		return {addr[4:0], addr} ^ 16'h5a3c;
	endfunction

	function automatic logic [3:0] rand_nib();
		logic [31:0] v;
		v = $random(seed);
		return v[3:0];
	endfunction

	// Cycles before ack rises or falls
	function automatic int ack_delay();
		logic [31:0] v;
		if (slow)
			return 5;
		v = $random(seed);
		return int'(v % 32'd6);
	endfunction

	//////////////////////////////
	// Instruction-level model
	//////////////////////////////

	function automatic void ncore_model(input int steps);
		logic [`NCORE_DW-1:0]  r [16];
		logic [`NCORE_DW-1:0]  mem [2**`NCORE_DAW];
		logic [`NCORE_DW-1:0]  a;
		logic [`NCORE_DW-1:0]  b;
		logic [`NCORE_DW:0]    wide;
		logic [4:0]            fl;
		logic [`NCORE_IAW-1:0] ip;
		logic [`NCORE_DAW-1:0] dp;
		logic [3:0]            lo;
		opcode_e               op;
		int                    amt;
		for (int k = 0; k < 2**`NCORE_DAW; k++)
			mem[k] = fill_word(k[`NCORE_DAW-1:0]);
		for (int k = 0; k < 16; k++)
			r[k] = '0;
		a  = '0;
		b  = '0;
		fl = '0;
		ip = '0;
		dp = '0;
		for (int s = 0; s < steps; s++) begin
			exp_fetch.push_back(ip);
			op  = opcode_e'(imem[ip][7:4]);
			lo  = imem[ip][3:0];
			amt = int'(b[3:0]);
			ip  = ip + 1'b1;
			case (op)
				op_mva: a = r[lo];
				op_mvb: b = r[lo];
				op_coa: a = {12'd0, lo};
				op_cob: b = {12'd0, lo};
				// Last bit pushed out of the top is A[DW - amount]
				op_shl: begin
					r[lo]         = a << amt;
					fl[flag_shl]  = (amt == 0) ? 1'b0 : a[`NCORE_DW - amt];
					fl[flag_zero] = ~|r[lo];
				end
				op_shr: begin
					r[lo]         = a >> amt;
					fl[flag_shr]  = (amt == 0) ? 1'b0 : a[amt - 1];
					fl[flag_zero] = ~|r[lo];
				end
				op_and: begin
					r[lo]         = a & b;
					fl[flag_zero] = ~|r[lo];
				end
				op_orr: begin
					r[lo]         = a | b;
					fl[flag_zero] = ~|r[lo];
				end
				op_xor: begin
					r[lo]         = a ^ b;
					fl[flag_zero] = ~|r[lo];
				end
				// Zero untouched by add
				op_add: begin
					wide          = {1'b0, a} + {1'b0, b};
					r[lo]         = wide[`NCORE_DW-1:0];
					fl[flag_carry] = wide[`NCORE_DW];
				end
				op_sub: begin
					wide            = {1'b0, a} - {1'b0, b};
					r[lo]           = wide[`NCORE_DW-1:0];
					fl[flag_borrow] = wide[`NCORE_DW];
					fl[flag_zero]   = ~|r[lo];
				end
				op_fmv: r[lo] = {11'd0, fl};
				op_mvd: begin
					exp_waddr.push_back(dp);
					exp_wdata.push_back(r[lo]);
					mem[dp] = r[lo];
				end
				op_mvp: dp = r[lo][`NCORE_DAW-1:0];
				op_jmp: if (a[0]) ip = r[lo][`NCORE_IAW-1:0];
				op_dmv: r[lo] = mem[dp];
				default: ;
			endcase
		end
		// The fetch after the last instruction ends the test
		exp_fetch.push_back(ip);
	endfunction

	//////////////////////////////
	// Memory responders
	//////////////////////////////

	initial begin
		imem_ack  = 1'b0;
		imem_data = 8'h00;
		forever begin
			@(posedge clk);
			if (imem_req) begin
				repeat (ack_delay()) @(posedge clk);
				imem_data <= imem[imem_addr];
				imem_ack  <= 1'b1;
				@(posedge clk);
				while (imem_req)
					@(posedge clk);
				repeat (ack_delay()) @(posedge clk);
				imem_ack <= 1'b0;
			end
		end
	end

	initial begin
		dmem_ack   = 1'b0;
		dmem_rdata = '0;
		forever begin
			@(posedge clk);
			if (dmem_req) begin
				repeat (ack_delay()) @(posedge clk);
				dmem_rdata <= dmem[dmem_addr];
				if (dmem_we)
					dmem[dmem_addr] = dmem_wdata;
				dmem_ack <= 1'b1;
				@(posedge clk);
				while (dmem_req)
					@(posedge clk);
				repeat (ack_delay()) @(posedge clk);
				dmem_ack <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Compare
	//////////////////////////////

	always @(posedge clk) begin
		if (!rst_n && !rst_q) begin
			assert (!imem_req && !dmem_req) else begin
				errors++;
				$display("%s: a request is high during reset", cur_test);
			end
		end else if (rst_n) begin
			if (imem_req && !imem_req_q) begin
				assert (exp_fetch.size() > 0) else begin
					errors++;
					$display("%s: fetch at %h after the end of the program", cur_test, imem_addr);
				end
				if (exp_fetch.size() > 0) begin
					want_ip = exp_fetch.pop_front();
					fetches++;
					assert (imem_addr == want_ip) else begin
						errors++;
						$display("mismatch %s fetch: expected %h actual %h", cur_test, want_ip,
							imem_addr);
					end
				end
			end
			if (dmem_req && !dmem_req_q && dmem_we) begin
				assert (exp_waddr.size() > 0) else begin
					errors++;
					$display("%s: data write to %h that the program never makes", cur_test,
						dmem_addr);
				end
				if (exp_waddr.size() > 0) begin
					want_addr = exp_waddr.pop_front();
					want_data = exp_wdata.pop_front();
					writes++;
					assert (dmem_addr == want_addr) else begin
						errors++;
						$display("mismatch %s write address: expected %h actual %h", cur_test,
							want_addr, dmem_addr);
					end
					assert (dmem_wdata == want_data) else begin
						errors++;
						$display("mismatch %s write data: expected %h actual %h", cur_test,
							want_data, dmem_wdata);
					end
				end
			end
		end
		imem_req_q <= imem_req;
		dmem_req_q <= dmem_req;
		rst_q      <= rst_n;
	end

	// Up to two slow handshakes of about 14 cycles each per instruction
	initial begin
		cycles = 0;
		while (cycles <= budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("watchdog: no end of test %s within %0d cycles", cur_test, budget);
		$display("fetches %0d, writes %0d, errors %0d", fetches, writes, errors);
		$display("STATUS: FAIL");
		$finish;
	end

	//////////////////////////////
	// Programs
	//////////////////////////////

	task automatic emit(input opcode_e op, input logic [3:0] lo);
		imem[pc] = {op, lo};
		pc++;
	endtask

	task automatic begin_test(input string name, input bit slow_acks);
		budget = budget + 18;
		@(posedge clk);
		rst_n    <= 1'b0;
		cur_test = name;
		slow     = slow_acks;
		pc       = 0;
		exp_fetch.delete();
		exp_waddr.delete();
		exp_wdata.delete();
		for (int k = 0; k < 2**`NCORE_IAW; k++)
			imem[k] = 8'h00;
		for (int k = 0; k < 2**`NCORE_DAW; k++)
			dmem[k] = fill_word(k[`NCORE_DAW-1:0]);
	endtask

	task automatic finish_test(input int steps);
		ncore_model(steps);
		budget = budget + (steps + 1) * 28;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		while (exp_fetch.size() > 0)
			@(posedge clk);
		assert (exp_waddr.size() == 0) else begin
			errors++;
			$display("%s: %0d expected data writes never happened", cur_test, exp_waddr.size());
		end
	endtask

	// Result goes to memory at its own value, then the flags on top
	task automatic alu_program();
		for (int k = 0; k < 7; k++) begin
			emit(op_coa, rand_nib());
			emit(op_cob, rand_nib());
			emit(alu_ops[k], 4'(k + 1));
			emit(op_mvp, 4'(k + 1));
			emit(op_mvd, 4'(k + 1));
			emit(op_fmv, 4'd15);
			emit(op_mvd, 4'd15);
		end
	endtask

	task automatic flags_program();
		// Sub sets zero and add must keep it
		emit(op_coa, 4'd3);
		emit(op_cob, 4'd3);
		emit(op_sub, 4'd1);
		emit(op_add, 4'd2);
		emit(op_fmv, 4'd3);
		emit(op_mvd, 4'd3);
		emit(op_cob, 4'd4);
		emit(op_sub, 4'd1);
		emit(op_fmv, 4'd3);
		emit(op_mvd, 4'd3);
		// Shift by zero, then by one
		emit(op_coa, 4'd9);
		emit(op_cob, 4'd0);
		emit(op_shr, 4'd4);
		emit(op_fmv, 4'd3);
		emit(op_mvd, 4'd3);
		emit(op_cob, 4'd1);
		emit(op_shr, 4'd4);
		emit(op_fmv, 4'd3);
		emit(op_mvd, 4'd3);
		// Large A gives shl-out and carry
		emit(op_coa, 4'd15);
		emit(op_cob, 4'd12);
		emit(op_shl, 4'd5);
		emit(op_mva, 4'd5);
		emit(op_cob, 4'd2);
		emit(op_shl, 4'd6);
		emit(op_mvb, 4'd5);
		emit(op_add, 4'd7);
		emit(op_fmv, 4'd3);
		emit(op_mvd, 4'd3);
	endtask

	task automatic data_program();
		emit(op_coa, 4'd9);
		emit(op_cob, 4'd0);
		emit(op_orr, 4'd1);
		emit(op_mvp, 4'd1);
		emit(op_coa, rand_nib());
		emit(op_cob, rand_nib());
		emit(op_xor, 4'd2);
		emit(op_mvd, 4'd2);
		// 192 holds the fill pattern
		emit(op_coa, 4'd12);
		emit(op_cob, 4'd4);
		emit(op_shl, 4'd3);
		emit(op_mvp, 4'd3);
		emit(op_dmv, 4'd4);
		emit(op_mvp, 4'd1);
		emit(op_dmv, 4'd5);
		emit(op_mvp, 4'd2);
		emit(op_mvd, 4'd4);
		emit(op_mvp, 4'd3);
		emit(op_mvd, 4'd5);
	endtask

	// Not taken at 3 and taken at 6 to address 9
	task automatic jump_program();
		emit(op_coa, 4'd8);
		emit(op_cob, 4'd0);
		emit(op_orr, 4'd1);
		emit(op_jmp, 4'd1);
		emit(op_coa, 4'd9);
		emit(op_orr, 4'd2);
		emit(op_jmp, 4'd2);
		emit(op_coa, 4'd15);
		emit(op_mvd, 4'd1);
		emit(op_mvd, 4'd2);
		emit(op_mvd, 4'd1);
	endtask

	initial begin
		rst_n = 1'b0;
		begin_test("alu", 1'b0);
		alu_program();
		finish_test(pc);
		begin_test("flags", 1'b0);
		flags_program();
		finish_test(pc);
		begin_test("data_path", 1'b0);
		data_program();
		finish_test(pc);
		begin_test("jumps", 1'b0);
		jump_program();
		finish_test(9);
		begin_test("backpressure", 1'b1);
		alu_program();
		data_program();
		finish_test(pc);
		$display("fetches %0d, writes %0d, errors %0d", fetches, writes, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- flist.f
+incdir+common
common/ncore_pkg.sv
ncore/ncore_sequencer.sv
ncore/ncore_decode.sv
ncore/ncore_execute.sv
ncore/ncore_result.sv
rtl/ncore_top.sv
dv/tb_clock.sv
dv/ncore_chk.sv
dv/tb_ncore.sv

//--- Makefile
# Verilator build and run of the ncore testbench

VERILATOR ?= verilator
TOP       ?= tb_ncore
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) common/ncore_settings.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a status line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
